//--- Makefile
TOP = tb_sdram

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

//--- build.f
src/sdram_geom_pkg.sv
src/sdram_cmd_pkg.sv
src/sdram_refresh_timer.sv
src/sdram_read_capture.sv
src/sdram_sequencer.sv
src/sdram_subsystem.sv
dv/sdram_model.sv
dv/tb_sdram.sv

//--- dv/sdram_model.sv
/*
 * Behavioural SDR SDRAM for the controller testbench, not synthesizable.
 * Sparse beat storage, per-bank open-row tracking, CAS 2 burst 2 reads and
 * checks on power-up order and command legality. Violations raise o_error.
 */
`timescale 1ns/1ps

module sdram_model
	import sdram_geom_pkg::*, sdram_cmd_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_reset,
	input  sdram_pins_t i_pins,
	output dq_t         o_dq,
	output logic        o_init_done,	// Mode register written
	output logic        o_error
);

	typedef logic [BANK_W+ROW_W+COL_W-1:0] beat_addr_t;	// {bank, row, column}

	dq_t        mem [beat_addr_t];	// Only written beats are stored
	logic [3:0] bank_open;
	row_t       open_row [4];
	int         init_step;		// 0 precharge, 1..2 refresh, 3 mode, 4 running
	logic       rd_busy;
	int         rd_age;		// Edges since READ was sampled
	beat_addr_t rd_addr;
	logic       wr_second;		// Second write beat arrives this edge
	beat_addr_t wr_addr;

	// Unwritten words, same rule as the testbench reference
	function automatic host_word_t fill_word(word_addr_t a);
		return {a, a[8:0]} ^ 32'h5A5A_C3C3;
	endfunction

	function automatic dq_t read_beat(beat_addr_t b);
		host_word_t w;
		if (mem.exists(b))
			return mem[b];
		w = fill_word({b[21:9], b[23:22], b[8:1]});	// Back to {row, bank, column word}
		return b[0] ? w[DQ_W-1:0] : w[HOST_W-1:DQ_W];	// Even beat is the high half
	endfunction

	function automatic beat_addr_t burst_addr(sdram_pins_t p);
		return {p.bs, open_row[p.bs], p.addr[COL_W-1:0]};
	endfunction

	task automatic report_violation(input string what);
		$display("SDRAM model: %s at %0t ns", what, $time);
		o_error <= 1'b1;
	endtask

	always @(posedge i_clock) begin
		if (i_reset) begin
			bank_open   = '0;
			init_step   = 0;
			rd_busy     = 1'b0;
			wr_second   = 1'b0;
			o_dq        <= '0;
			o_init_done <= 1'b0;
			o_error     <= 1'b0;
		end else begin
			o_dq <= '0;
			// ============================================================
			// Data beats in flight
			// ============================================================
			if (rd_busy) begin
				if (rd_age == CAS_CYCLES - 1)
					o_dq <= read_beat(rd_addr);	// Seen by the controller CAS_CYCLES after READ
				if (rd_age == CAS_CYCLES) begin
					o_dq    <= read_beat({rd_addr[23:1], 1'b1});
					rd_busy = 1'b0;
				end
				rd_age++;
			end
			if (wr_second) begin
				if (!i_pins.dq_oe)
					report_violation("second write beat without DQ driven");
				mem[{wr_addr[23:1], 1'b1}] = i_pins.dq_out;
				wr_second = 1'b0;
			end
			if (i_pins.cmd != CMD_NOP && !i_pins.cke)
				report_violation("command issued while CKE is low");

			// ============================================================
			// Command decode
			// ============================================================
			case (i_pins.cmd)
				CMD_NOP: ;
				CMD_PRECHARGE: begin
					if (init_step == 0 && i_pins.addr[10])
						init_step = 1;
					else if (init_step < 4)
						report_violation("precharge out of order during power-up");
					if (i_pins.addr[10])
						bank_open = '0;		// All banks
					else
						bank_open[i_pins.bs] = 1'b0;
				end
				CMD_REFRESH: begin
					if (bank_open != '0)
						report_violation("refresh with a row still open");
					if (init_step == 1 || init_step == 2)
						init_step++;
					else if (init_step < 4)
						report_violation("refresh out of order during power-up");
				end
				CMD_SET_MODE: begin
					if (init_step != 3)
						report_violation("mode register set out of order");
					if (i_pins.addr[2:0] != BL_2 || i_pins.addr[6:4] != CL_2 ||
						i_pins.addr[3] || i_pins.addr[9] != WB_BURST)
						report_violation("mode register is not CAS 2, burst 2, sequential");
					init_step = 4;
					o_init_done <= 1'b1;
				end
				CMD_ACTIVATE: begin
					if (init_step != 4)
						report_violation("activate before the power-up sequence finished");
					if (bank_open[i_pins.bs])
						report_violation("activate to a bank that already has a row open");
					bank_open[i_pins.bs] = 1'b1;
					open_row[i_pins.bs]  = i_pins.addr;
				end
				CMD_READ, CMD_WRITE: begin
					if (!bank_open[i_pins.bs])
						report_violation("read or write to a bank with no open row");
					if (!i_pins.addr[10] || i_pins.addr[0])
						report_violation("access without auto-precharge or at an odd column");
					if (i_pins.cmd == CMD_READ) begin
						if (rd_busy || i_pins.dq_oe)
							report_violation("read overlaps another transfer on DQ");
						rd_busy = 1'b1;
						rd_age  = 1;
						rd_addr = burst_addr(i_pins);
					end else begin
						if (!i_pins.dq_oe)
							report_violation("first write beat without DQ driven");
						wr_addr      = burst_addr(i_pins);
						mem[wr_addr] = i_pins.dq_out;
						wr_second    = 1'b1;
					end
					bank_open[i_pins.bs] = 1'b0;	// Auto-precharge closes the row
				end
				default: report_violation("unknown command encoding on the bus");
			endcase
		end
	end

endmodule

//--- dv/tb_sdram.sv
/*
 * Testbench for the SDRAM controller top level with a behavioural device.
 * Checks power-up order, write/read back, LFSR mixed traffic against a
 * reference memory, refresh spacing and a held host request.
 */
`timescale 1ns/1ps

module tb_sdram
	import sdram_geom_pkg::*, sdram_cmd_pkg::*;
();

	localparam int STARTUP_CYCLES   = 40;
	localparam int REFRESH_INTERVAL = 120;
	localparam int T_RP             = 4;
	localparam int T_RFC            = 8;
	localparam int T_MRD            = 2;
	localparam int T_RCD            = 5;
	localparam int CLK_PERIOD       = 10;
	localparam int N_RANDOM         = 200;
	localparam int HOLD_CYCLES      = 20;
	localparam int MAX_ACCESS       = 40;		// Request to idle again with margin
	localparam int REFRESH_COST     = 4 + T_RFC;
	localparam int REFRESH_LIMIT    = REFRESH_INTERVAL + MAX_ACCESS + HOLD_CYCLES;
	localparam int WATCHDOG_NS      = (STARTUP_CYCLES + 100 + HOLD_CYCLES +
		(N_RANDOM + 3) * (MAX_ACCESS + REFRESH_COST)) * CLK_PERIOD;
	localparam word_addr_t WR_ADDR  = {13'h1ABC, 2'd2, 8'h5F};

	logic        clock;
	logic        reset;
	logic        request;
	mem_req_t    req;
	host_word_t  rdata;
	logic        ready;
	dq_t         dq;
	sdram_pins_t pins;
	logic        model_init_done;
	logic        model_error;

	sdram_subsystem #(
		.STARTUP_CYCLES(STARTUP_CYCLES), .REFRESH_INTERVAL(REFRESH_INTERVAL),
		.T_RP(T_RP), .T_RFC(T_RFC), .T_MRD(T_MRD), .T_RCD(T_RCD)
	) DUT (
		.i_clock(clock), .i_reset(reset), .i_request(request), .i_req(req),
		.o_rdata(rdata), .o_ready(ready), .i_dq(dq), .o_pins(pins)
	);

	sdram_model u_model (
		.i_clock(clock), .i_reset(reset), .i_pins(pins), .o_dq(dq),
		.o_init_done(model_init_done), .o_error(model_error)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// ============================================================
	// Stimulus source and reference memory
	// ============================================================
	logic [15:0] lfsr_state;
	host_word_t  ref_mem [word_addr_t];
	int          reads_issued;
	int          reads_checked;

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// x^16 + x^14 + x^13 + x^11 + 1
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic host_word_t fill_word(word_addr_t a);
		return {a, a[8:0]} ^ 32'h5A5A_C3C3;
	endfunction

	function automatic host_word_t expected_read(word_addr_t a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return fill_word(a);
	endfunction

	// Two row bits (top and bottom), every bank, four column words
	function automatic word_addr_t narrow_addr(logic [5:0] b);
		row_t r;
		r = {b[5], 11'h000, b[4]};
		return {r, b[3:2], 6'h00, b[1:0]};
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAIL %0t ns: %s got %08h expected %08h", $time, what, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s at %0t ns", why, $time);
		$display("Verification failed");
		$fatal(1, "run stopped");
	endtask

	// ============================================================
	// Pin monitor for power-up, refresh spacing and ACTIVATE rules
	// ============================================================
	int         cycle;		// Edges since reset release
	int         activate_count;
	int         refresh_pairs;
	int         refresh_gap;
	sdram_cmd_e prev_cmd;
	logic [2:0] due_hist;		// Expected refresh-due level with [0] after the last edge
	logic       due_next;

	always @(posedge clock) begin
		if (reset) begin
			cycle          = 0;
			refresh_gap    = 0;
			prev_cmd       = CMD_NOP;
			due_hist       = '0;
			activate_count <= 0;
			refresh_pairs  <= 0;
		end else begin
			cycle++;
			refresh_gap++;
			if (cycle <= STARTUP_CYCLES / 4 + 1) begin
				check_value(32'(pins.cke), 32'd0, "cke before the three-quarter point");
				check_value(32'(pins.dqm), 32'd3, "dqm before the three-quarter point");
			end
			if (cycle == STARTUP_CYCLES / 4 + 2) begin
				check_value(32'(pins.cke), 32'd1, "cke after the three-quarter point");
				check_value(32'(pins.dqm), 32'd0, "dqm after the three-quarter point");
			end
			if (pins.cmd == CMD_ACTIVATE) begin
				activate_count <= activate_count + 1;
				if (due_hist[2])	// Idle state saw due set two edges before the pins
					stop_run("ACTIVATE issued while a refresh was due");
			end
			if (pins.cmd == CMD_WRITE)
				check_value(32'(pins.dq_out), 32'(req.wdata[31:16]), "first write beat");
			if (pins.cmd == CMD_REFRESH && prev_cmd == CMD_REFRESH) begin
				refresh_pairs <= refresh_pairs + 1;
				refresh_gap   = 0;
			end
			if (refresh_gap > REFRESH_LIMIT)
				stop_run("No refresh pair within one interval plus an access");
			due_next = due_hist[0] && pins.cmd != CMD_REFRESH;
			if (cycle % REFRESH_INTERVAL == 0)
				due_next = 1'b1;	// New interval wins over the clear
			due_hist = {due_hist[1:0], due_next};
			prev_cmd = pins.cmd;
		end
	end

	always @(posedge clock) begin
		if (!reset && model_error)
			stop_run("SDRAM model saw an illegal command sequence");
	end

	// ============================================================
	// Compare process checking each rising o_ready
	// ============================================================
	logic ready_q;

	always @(posedge clock) begin
		if (reset) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= ready;
			if (ready && !ready_q) begin
				if (req.rw) begin
					ref_mem[req.addr] = req.wdata;
				end else begin
					check_value(rdata, expected_read(req.addr), "read data");
					reads_checked++;
				end
			end
		end
	end

	// Holds the request until o_ready, optionally longer, then waits for ready low
	task automatic run_access(input logic rw, input word_addr_t addr, input host_word_t wdata,
		input int hold);
		int act_before;
		@(posedge clock);
		#1;
		req.rw    = rw;
		req.addr  = addr;
		req.wdata = wdata;
		request   = 1'b1;
		if (!rw)
			reads_issued++;
		@(posedge clock);
		while (!ready)
			@(posedge clock);
		act_before = activate_count;
		repeat (hold) begin
			@(posedge clock);
			if (!ready)
				stop_run("o_ready dropped while the request was still held");
			check_value(activate_count, act_before, "ACTIVATE count under held request");
		end
		#1 request = 1'b0;
		@(posedge clock);
		while (ready)
			@(posedge clock);
	endtask

	initial begin
		logic [31:0] bits;
		logic        rw;
		word_addr_t  addr;
		request       = 1'b0;
		req           = '0;
		reset         = 1'b1;
		lfsr_state    = 16'd15822;
		reads_issued  = 0;
		reads_checked = 0;
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;

		run_access(1'b1, WR_ADDR, 32'hCAFE_1234, 0);	// Request waits out power-up
		run_access(1'b0, WR_ADDR, '0, 0);
		for (int n = 0; n < N_RANDOM; n++) begin
			draw_bits(1, bits);
			rw = bits[0];
			draw_bits(6, bits);
			addr = narrow_addr(bits[5:0]);
			draw_bits(32, bits);
			run_access(rw, addr, bits, 0);
		end
		run_access(1'b0, WR_ADDR, '0, HOLD_CYCLES);

		if (reads_checked == reads_issued && refresh_pairs >= 2 && model_init_done) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Incomplete run: %0d of %0d reads checked, %0d refresh pairs",
				reads_checked, reads_issued, refresh_pairs);
			$display("Verification failed");
			$fatal(1, "run incomplete");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_run("Timeout: the traffic did not finish in the expected time");
	end

endmodule

//--- src/sdram_cmd_pkg.sv
/*
 * SDRAM command encodings, mode-register fields and the pin bus.
 * Shared by the controller, the behavioural device model and the testbench.
 * The read pipeline depth constants fix where read beats are sampled.
 */
package sdram_cmd_pkg;

	import sdram_geom_pkg::*;

	// ============================================================
	// Command bus {cs_n, ras_n, cas_n, we_n}
	// ============================================================
	typedef enum logic [3:0] {
		CMD_NOP       = 4'b0111,
		CMD_PRECHARGE = 4'b0010,
		CMD_SET_MODE  = 4'b0000,
		CMD_REFRESH   = 4'b0001,
		CMD_ACTIVATE  = 4'b0011,
		CMD_READ      = 4'b0101,
		CMD_WRITE     = 4'b0100
	} sdram_cmd_e;

	// Mode-register fields
	typedef enum logic [2:0] {CL_2 = 3'b010, CL_3 = 3'b011} cas_latency_e;
	typedef enum logic [2:0] {
		BL_1 = 3'b000, BL_2 = 3'b001, BL_4 = 3'b010, BL_8 = 3'b011, BL_PAGE = 3'b111
	} burst_len_e;
	typedef enum logic [0:0] {WB_BURST = 1'b0, WB_SINGLE = 1'b1} write_burst_e;

	typedef logic [ROW_W-1:0] pin_addr_t;

	localparam pin_addr_t ADDR_A10 = 13'h0400;	// Precharge all / auto-precharge
	// Reserved, write burst, op mode, CAS, sequential, burst length
	localparam pin_addr_t MODE_WORD = {3'b000, WB_BURST, 2'b00, CL_2, 1'b0, BL_2};

	localparam int CAS_CYCLES     = 2;	// Must match CL_2 above
	localparam int CAPTURE_STAGES = 2;	// DQ re-register depth in the controller

	// Everything the controller drives toward the device
	typedef struct packed {
		logic       cke;
		logic [1:0] dqm;
		sdram_cmd_e cmd;
		bank_t      bs;
		pin_addr_t  addr;
		dq_t        dq_out;
		logic       dq_oe;	// High while the controller owns DQ
	} sdram_pins_t;

endpackage

//--- src/sdram_geom_pkg.sv
/*
 * Address geometry and host-side types for the SDR SDRAM controller.
 * A host word address maps to row, bank and column fields of a 16-bit part
 * with 4 banks, 13 row bits and 9 column bits. Each 32-bit word is two beats.
 */
package sdram_geom_pkg;

	// ============================================================
	// Field widths
	// ============================================================
	localparam int ROW_W       = 13;	// A12..A0 on activate
	localparam int BANK_W      = 2;		// BA1..BA0
	localparam int COL_W       = 9;		// Column in 16-bit beats
	localparam int COL_WORD_W  = COL_W - 1;	// Column in 32-bit words
	localparam int WORD_ADDR_W = ROW_W + BANK_W + COL_WORD_W;
	localparam int HOST_W      = 32;
	localparam int DQ_W        = 16;

	typedef logic [WORD_ADDR_W-1:0] word_addr_t;	// {row, bank, column word}
	typedef logic [ROW_W-1:0]       row_t;
	typedef logic [BANK_W-1:0]      bank_t;
	typedef logic [COL_W-1:0]       col_t;
	typedef logic [HOST_W-1:0]      host_word_t;
	typedef logic [DQ_W-1:0]        dq_t;

	// Host request, held stable while the request level is high
	typedef struct packed {
		logic       rw;		// 1 = write
		word_addr_t addr;
		host_word_t wdata;
	} mem_req_t;

	// Address split, row on top so a linear walk stays inside a row
	function automatic row_t addr_row(word_addr_t a);
		return a[WORD_ADDR_W-1 -: ROW_W];
	endfunction

	function automatic bank_t addr_bank(word_addr_t a);
		return a[COL_WORD_W +: BANK_W];
	endfunction

	function automatic col_t addr_col(word_addr_t a);
		return {a[COL_WORD_W-1:0], 1'b0};	// Even beat starts the burst
	endfunction

endpackage

//--- src/sdram_read_capture.sv
/*
 * Read data path from the SDRAM DQ pins.
 * DQ passes through CAPTURE_STAGES flops to ease pad timing, then the
 * sequencer's take pulses latch the high beat and the low beat into one word.
 */
`timescale 1ns/1ps

module sdram_read_capture
	import sdram_geom_pkg::*, sdram_cmd_pkg::*;
(
	input  logic       i_clock,
	input  logic       i_reset,
	input  dq_t        i_dq,
	input  logic       i_take_hi,
	input  logic       i_take_lo,
	output host_word_t o_word
);

	// ============================================================
	// DQ re-register pipeline
	// ============================================================
	dq_t r_dq_pipe [CAPTURE_STAGES];	// [0] is the pad-side flop

	always_ff @(posedge i_clock) begin
		r_dq_pipe[0] <= i_dq;
		for (int i = 1; i < CAPTURE_STAGES; i++)
			r_dq_pipe[i] <= r_dq_pipe[i-1];
	end

	// ============================================================
	// Word assembly, first beat is the upper half
	// ============================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_word <= '0;
		end else begin
			if (i_take_hi)
				o_word[HOST_W-1:DQ_W] <= r_dq_pipe[CAPTURE_STAGES-1];
			if (i_take_lo)
				o_word[DQ_W-1:0] <= r_dq_pipe[CAPTURE_STAGES-1];	// Second beat
		end
	end

	// Beats arrive on consecutive cycles, never both at once
	a_take_exclusive : assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_take_hi && i_take_lo));

endmodule

//--- src/sdram_refresh_timer.sv
/*
 * Periodic refresh request for the SDRAM sequencer.
 * Raises a sticky due flag every REFRESH_INTERVAL cycles; the sequencer
 * clears it with a one-cycle ack when it starts a refresh pair.
 */
`timescale 1ns/1ps

module sdram_refresh_timer #(
	parameter int REFRESH_INTERVAL = 500
)(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_refresh_ack,
	output logic o_refresh_due
);

	localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);
	typedef logic [CNT_W-1:0] interval_t;
	localparam interval_t LAST = interval_t'(REFRESH_INTERVAL - 1);

	interval_t r_count;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			r_count       <= '0;
			o_refresh_due <= 1'b0;
		end else begin
			r_count <= (r_count == LAST) ? '0 : r_count + 1'b1;	// Free running, ack or not
			if (r_count == LAST)
				o_refresh_due <= 1'b1;			// New interval wins over a same-cycle ack
			else if (i_refresh_ack)
				o_refresh_due <= 1'b0;
		end
	end

	// Sequencer only takes a refresh that was actually requested
	a_ack_when_due : assert property (@(posedge i_clock) disable iff (i_reset)
		i_refresh_ack |-> o_refresh_due);

endmodule

//--- src/sdram_sequencer.sv
/*
 * Main SDRAM control FSM: power-up sequence, periodic double refresh and
 * single-word accesses as a burst of two with auto-precharge.
 * All pin outputs are registered. Read beats are expected on DQ at the edge
 * CAS_CYCLES after the device samples READ.
 */
`timescale 1ns/1ps

module sdram_sequencer
	import sdram_geom_pkg::*, sdram_cmd_pkg::*;
#(
	parameter int STARTUP_CYCLES = 20000,
	parameter int T_RP           = 4,
	parameter int T_RFC          = 8,
	parameter int T_MRD          = 2,
	parameter int T_RCD          = 5
)(
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_request,		// Level, held until o_ready
	input  mem_req_t    i_req,
	input  logic        i_refresh_due,
	output logic        o_refresh_ack,	// One-cycle pulse
	output logic        o_take_hi,
	output logic        o_take_lo,
	output logic        o_ready,
	output sdram_pins_t o_pins
);

	function automatic int max2(int a, int b);
		return (a > b) ? a : b;
	endfunction

	// ============================================================
	// Wait counts
	// ============================================================
	localparam int TAKE_HI_AT = CAS_CYCLES + CAPTURE_STAGES;	// Edges after READ issue
	localparam int XFER_WAIT  = max2(T_RCD, TAKE_HI_AT + 1);	// Room for both beats
	localparam int CNT_MAX    = max2(max2(STARTUP_CYCLES, XFER_WAIT),
		max2(max2(T_RP, T_RFC), max2(T_MRD, T_RCD)));
	localparam int CNT_W      = $clog2(CNT_MAX + 1);

	typedef logic [CNT_W-1:0] count_t;

	localparam count_t CNT_STARTUP = count_t'(STARTUP_CYCLES);
	localparam count_t CKE_AT      = count_t'((STARTUP_CYCLES * 3) / 4);	// 3/4 remaining
	localparam count_t TAKE_HI_CNT = count_t'(XFER_WAIT - TAKE_HI_AT + 1);
	localparam count_t TAKE_LO_CNT = count_t'(XFER_WAIT - TAKE_HI_AT);
	localparam count_t CNT_XFER    = count_t'(XFER_WAIT);

	typedef enum logic [4:0] {
		ST_STARTUP,
		ST_INIT_PRECHARGE,
		ST_INIT_WAIT_PRECHARGE,
		ST_INIT_REFRESH_1,
		ST_INIT_REFRESH_2,
		ST_INIT_WAIT_REFRESH,
		ST_SET_MODE,
		ST_WAIT_MODE,
		ST_IDLE,
		ST_REFRESH_1,
		ST_REFRESH_2,
		ST_WAIT_REFRESH,
		ST_ACTIVATE,
		ST_WAIT_ACTIVATE,
		ST_READ,
		ST_WAIT_READ,
		ST_WRITE,
		ST_WAIT_WRITE,
		ST_WAIT_PRECHARGE
	} state_e;

	state_e   r_state;
	count_t   r_count;	// Shared down counter for every wait
	mem_req_t r_req;	// Request latched in idle

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			r_state       <= ST_STARTUP;
			r_count       <= CNT_STARTUP;
			o_pins.cke    <= 1'b0;
			o_pins.dqm    <= 2'b11;	// Device outputs masked during power-up
			o_pins.cmd    <= CMD_NOP;
			o_pins.dq_oe  <= 1'b0;
			o_ready       <= 1'b0;
			o_refresh_ack <= 1'b0;
			o_take_hi     <= 1'b0;
			o_take_lo     <= 1'b0;
		end else begin
			// Defaults, command states override
			o_pins.cmd    <= CMD_NOP;
			o_refresh_ack <= 1'b0;
			o_take_hi     <= 1'b0;
			o_take_lo     <= 1'b0;
			if (r_count != '0)
				r_count <= r_count - 1'b1;

			case (r_state)
				// ============================================================
				// Power-up
				// ============================================================
				ST_STARTUP: begin
					if (r_count <= CKE_AT) begin	// Clock enable after the first quarter
						o_pins.cke <= 1'b1;
						o_pins.dqm <= 2'b00;
					end
					if (r_count == '0)
						r_state <= ST_INIT_PRECHARGE;
				end
				ST_INIT_PRECHARGE: begin
					o_pins.cmd  <= CMD_PRECHARGE;
					o_pins.bs   <= '0;
					o_pins.addr <= ADDR_A10;	// All banks
					r_count     <= count_t'(T_RP);
					r_state     <= ST_INIT_WAIT_PRECHARGE;
				end
				ST_INIT_WAIT_PRECHARGE:
					if (r_count == '0) r_state <= ST_INIT_REFRESH_1;
				ST_INIT_REFRESH_1: begin
					o_pins.cmd <= CMD_REFRESH;
					r_state    <= ST_INIT_REFRESH_2;
				end
				ST_INIT_REFRESH_2: begin
					o_pins.cmd <= CMD_REFRESH;
					r_count    <= count_t'(T_RFC);
					r_state    <= ST_INIT_WAIT_REFRESH;
				end
				ST_INIT_WAIT_REFRESH:
					if (r_count == '0) r_state <= ST_SET_MODE;
				ST_SET_MODE: begin
					o_pins.cmd  <= CMD_SET_MODE;
					o_pins.bs   <= '0;
					o_pins.addr <= MODE_WORD;	// CAS 2, burst 2, sequential
					r_count     <= count_t'(T_MRD);
					r_state     <= ST_WAIT_MODE;
				end
				ST_WAIT_MODE:
					if (r_count == '0) r_state <= ST_IDLE;

				// ============================================================
				// Run time
				// ============================================================
				ST_IDLE: begin
					o_pins.dq_oe <= 1'b0;
					if (i_refresh_due) begin	// Refresh beats a waiting host
						o_refresh_ack <= 1'b1;
						r_state       <= ST_REFRESH_1;
					end else if (i_request) begin
						r_req   <= i_req;
						r_state <= ST_ACTIVATE;
					end
				end
				ST_REFRESH_1: begin
					o_pins.cmd <= CMD_REFRESH;
					r_state    <= ST_REFRESH_2;
				end
				ST_REFRESH_2: begin
					o_pins.cmd <= CMD_REFRESH;
					r_count    <= count_t'(T_RFC);
					r_state    <= ST_WAIT_REFRESH;
				end
				ST_WAIT_REFRESH:
					if (r_count == '0) r_state <= ST_IDLE;
				ST_ACTIVATE: begin
					o_pins.cmd  <= CMD_ACTIVATE;
					o_pins.bs   <= addr_bank(r_req.addr);
					o_pins.addr <= addr_row(r_req.addr);
					r_count     <= count_t'(T_RCD);
					r_state     <= ST_WAIT_ACTIVATE;
				end
				ST_WAIT_ACTIVATE: begin
					if (r_count == '0) begin
						// Column with A10 for auto-precharge, first beat staged early
						o_pins.addr   <= pin_addr_t'(addr_col(r_req.addr)) | ADDR_A10;
						o_pins.dq_out <= r_req.wdata[HOST_W-1:DQ_W];
						o_pins.dq_oe  <= r_req.rw;
						r_state       <= r_req.rw ? ST_WRITE : ST_READ;
					end
				end
				ST_READ: begin
					o_pins.cmd <= CMD_READ;
					r_count    <= CNT_XFER;
					r_state    <= ST_WAIT_READ;
				end
				ST_WAIT_READ: begin
					o_take_hi <= (r_count == TAKE_HI_CNT);	// Beat 0 leaves the capture pipe
					o_take_lo <= (r_count == TAKE_LO_CNT);
					if (r_count == '0) begin
						o_ready <= 1'b1;	// Word is latched on this same edge
						r_count <= count_t'(T_RP);
						r_state <= ST_WAIT_PRECHARGE;
					end
				end
				ST_WRITE: begin
					o_pins.cmd <= CMD_WRITE;	// Beat 0 goes with the command
					r_count    <= CNT_XFER;
					r_state    <= ST_WAIT_WRITE;
				end
				ST_WAIT_WRITE: begin
					if (r_count == CNT_XFER)
						o_pins.dq_out <= r_req.wdata[DQ_W-1:0];
					else
						o_pins.dq_oe <= 1'b0;	// Release DQ after beat 1
					if (r_count == '0) begin
						o_ready <= 1'b1;
						r_count <= count_t'(T_RP);
						r_state <= ST_WAIT_PRECHARGE;
					end
				end
				ST_WAIT_PRECHARGE: begin
					if (!i_request)
						o_ready <= 1'b0;
					// Hold here while the host keeps its request up
					if (r_count == '0 && !o_ready)
						r_state <= ST_IDLE;
				end
				default: r_state <= ST_STARTUP;
			endcase
		end
	end

	// No command reaches the device before its clock is enabled
	a_cmd_needs_cke : assert property (@(posedge i_clock) disable iff (i_reset)
		(o_pins.cmd != CMD_NOP) |-> o_pins.cke);

endmodule

//--- src/sdram_subsystem.sv
/*
 * SDRAM controller top level for a 16-bit SDR device.
 * Connects the sequencer, refresh timer and read capture; all timing counts
 * are set here and passed down. Host uses a held request and a ready level.
 */
`timescale 1ns/1ps

module sdram_subsystem
	import sdram_geom_pkg::*, sdram_cmd_pkg::*;
#(
	parameter int STARTUP_CYCLES   = 20000,
	parameter int REFRESH_INTERVAL = 500,
	parameter int T_RP             = 4,
	parameter int T_RFC            = 8,
	parameter int T_MRD            = 2,
	parameter int T_RCD            = 5
)(
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_request,
	input  mem_req_t    i_req,
	output host_word_t  o_rdata,	// Valid while o_ready after a read
	output logic        o_ready,
	input  dq_t         i_dq,
	output sdram_pins_t o_pins
);

	logic refresh_due;
	logic refresh_ack;
	logic take_hi;
	logic take_lo;

	sdram_sequencer #(
		.STARTUP_CYCLES(STARTUP_CYCLES),
		.T_RP(T_RP), .T_RFC(T_RFC), .T_MRD(T_MRD), .T_RCD(T_RCD)
	) u_sequencer (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_request(i_request), .i_req(i_req),
		.i_refresh_due(refresh_due), .o_refresh_ack(refresh_ack),
		.o_take_hi(take_hi), .o_take_lo(take_lo),
		.o_ready(o_ready), .o_pins(o_pins)
	);

	sdram_refresh_timer #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) u_refresh_timer (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_refresh_ack(refresh_ack), .o_refresh_due(refresh_due)
	);

	sdram_read_capture u_read_capture (
		.i_clock(i_clock), .i_reset(i_reset), .i_dq(i_dq),
		.i_take_hi(take_hi), .i_take_lo(take_lo), .o_word(o_rdata)
	);

endmodule
